//--- fir_pkg.sv
// fir widths, tap counts, rounding constant, dsp mode, tap operation and sample pair types
package fir_pkg;

   localparam int SAMPLE_W   = 16;                  // signed input samples
   localparam int AD_W       = 25;                  // pre-adder operand, as on the A/D ports
   localparam int COEF_W     = 18;                  // B port width
   localparam int ACC_W      = 48;                  // P width
   localparam int NTAPS      = 16;
   localparam int NPAIRS     = NTAPS / 2;           // linear phase, one coef per pair
   localparam int PAIR_IDX_W = $clog2(NPAIRS);
   localparam int TAP_IDX_W  = $clog2(NTAPS);       // ring pointer width
   localparam int DSP_LAT    = 4;                   // input reg, AD, M, P
   localparam int OUT_SHIFT  = 17;                  // bits dropped off the accumulator
   localparam int OUT_W      = 24;

   // half lsb of the output, loaded through C on the first pair
   localparam logic signed [ACC_W-1:0] ROUND_C = ACC_W'(1) << (OUT_SHIFT - 1);

   typedef struct packed {
      logic z_load;     // p = c + m when set, else p = p + m
      logic preadd_sub; // ad = a - d when set
   } dsp_mode_t;

   typedef struct packed {
      logic                     valid;
      dsp_mode_t                mode;
      logic signed [COEF_W-1:0] coef;
      logic                     last; // final pair of a pass
   } tap_op_t;

   typedef struct packed {
      logic signed [SAMPLE_W-1:0] x_new; // tap k
      logic signed [SAMPLE_W-1:0] x_old; // tap NTAPS-1-k
   } sample_pair_t;

endpackage

//--- dsp_slice.sv
// dsp_slice: behavioral pre-add, multiply and accumulate slice with A/D, AD, M and P registers
module dsp_slice (
   input  logic                              clock,
   input  logic signed [fir_pkg::AD_W-1:0]   a,
   input  logic signed [fir_pkg::AD_W-1:0]   d,
   input  logic signed [fir_pkg::COEF_W-1:0] b,
   input  logic signed [fir_pkg::ACC_W-1:0]  c,     // one register only, meets M at the alu
   input  fir_pkg::dsp_mode_t                mode,
   output logic signed [fir_pkg::ACC_W-1:0]  p
);
   import fir_pkg::*;

   localparam int M_W = AD_W + COEF_W;

   // stage 1, input registers
   logic signed [AD_W-1:0]   a_r, d_r;
   logic signed [COEF_W-1:0] b_r;
   dsp_mode_t                mode_1;

   // stage 2, pre-adder register
   logic signed [AD_W-1:0]   ad_r;
   logic signed [COEF_W-1:0] b_r2;   // second B register keeps b beside ad
   dsp_mode_t                mode_2;

   // stage 3, multiplier register
   logic signed [M_W-1:0]    m_r;
   logic signed [ACC_W-1:0]  c_r;
   dsp_mode_t                mode_3;

   // no resets anywhere, like the hard block
   always_ff @(posedge clock) begin
      a_r    <= a;
      d_r    <= d;
      b_r    <= b;
      mode_1 <= mode;

      // pre-add or pre-subtract, samples are narrow so AD_W cannot overflow
      if (mode_1.preadd_sub)
         ad_r <= a_r - d_r;
      else
         ad_r <= a_r + d_r;
      b_r2   <= b_r;
      mode_2 <= mode_1;

      m_r    <= ad_r * b_r2;   // full 43 bit product
      c_r    <= c;
      mode_3 <= mode_2;

      // z mux picks c on a load, p otherwise
      if (mode_3.z_load)
         p <= c_r + m_r;
      else
         p <= p + m_r;
   end

endmodule

//--- sample_delay_line.sv
// sample_delay_line: 16 entry sample ring with a registered symmetric pair read
module sample_delay_line (
   input  logic                                clock,
   input  logic                                sample_wr,
   input  logic signed [fir_pkg::SAMPLE_W-1:0] sample,
   input  logic                                tap_rd,
   input  logic [fir_pkg::PAIR_IDX_W-1:0]      pair_idx,
   output fir_pkg::sample_pair_t               pair
);
   import fir_pkg::*;

   logic signed [SAMPLE_W-1:0] ring [NTAPS];
   logic [TAP_IDX_W-1:0]       wr_ptr = '0;  // power-up value, any start point works
   logic [TAP_IDX_W-1:0]       addr_new;     // tap k
   logic [TAP_IDX_W-1:0]       addr_old;     // tap NTAPS-1-k

   // newest sample sits just behind the write pointer
   assign addr_new = wr_ptr - TAP_IDX_W'(1) - TAP_IDX_W'(pair_idx);
   // wp-1-(15-k) wraps to wp+k
   assign addr_old = wr_ptr + TAP_IDX_W'(pair_idx);

   always_ff @(posedge clock) begin
      if (sample_wr) begin
         ring[wr_ptr] <= sample;
         wr_ptr       <= wr_ptr + TAP_IDX_W'(1);
      end
      // read sees ring and pointer from before this edge
      if (tap_rd) begin
         pair.x_new <= ring[addr_new];
         pair.x_old <= ring[addr_old];
      end
   end

endmodule

//--- tap_sequencer.sv
// tap_sequencer: strobe accept/drop, coefficient bank, pair counter and tap operation issue
module tap_sequencer (
   input  logic                              clock,
   input  logic                              arst_n,
   input  logic                              sample_stb,
   input  logic                              antisym,
   input  logic                              coef_we,
   input  logic [fir_pkg::PAIR_IDX_W-1:0]    coef_addr,
   input  logic signed [fir_pkg::COEF_W-1:0] coef_data,
   output logic                              sample_wr,
   output logic                              tap_rd,
   output logic [fir_pkg::PAIR_IDX_W-1:0]    pair_idx,
   output fir_pkg::tap_op_t                  op,
   output logic                              overrun
);
   import fir_pkg::*;

   logic signed [COEF_W-1:0] coef_bank [NPAIRS];
   logic                     busy;       // pass in progress
   logic [PAIR_IDX_W-1:0]    cnt;        // next pair to issue
   logic                     antisym_q;  // mode of the current pass
   tap_op_t                  iss;        // op issued beside tap_rd, waits one cycle for the pair
   logic                     first_pair;
   logic                     last_pair;

   // strobes only land when idle, a busy strobe is dropped whole
   assign sample_wr = sample_stb & ~busy;
   assign overrun   = sample_stb & busy;

   assign first_pair = (cnt == '0);
   assign last_pair  = (cnt == PAIR_IDX_W'(NPAIRS - 1));

   // write port, takes effect next clock
   always_ff @(posedge clock) begin
      if (coef_we)
         coef_bank[coef_addr] <= coef_data;
   end

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         busy      <= 1'b0;
         cnt       <= '0;
         antisym_q <= 1'b0;
         tap_rd    <= 1'b0;
         pair_idx  <= '0;
         iss       <= '0;
         op        <= '0;
      end else begin
         tap_rd <= busy;            // one read per busy cycle
         iss    <= '0;
         if (busy) begin
            pair_idx            <= cnt;
            iss.valid           <= 1'b1;
            iss.mode.z_load     <= first_pair;   // first pair reloads from c
            iss.mode.preadd_sub <= antisym_q;
            iss.coef            <= coef_bank[cnt];
            iss.last            <= last_pair;
            cnt                 <= cnt + PAIR_IDX_W'(1);
            if (last_pair)
               busy <= 1'b0;        // idle again one cycle after the last issue
         end
         if (sample_wr) begin
            busy      <= 1'b1;
            cnt       <= '0;
            antisym_q <= antisym;   // held for the whole pass
         end
         op <= iss;                 // lines up with the registered pair
      end
   end

endmodule

//--- fir_mac.sv
// fir_mac: dsp slice feed, last pair flag pipe and scaled result capture
module fir_mac (
   input  logic                             clock,
   input  logic                             arst_n,
   input  fir_pkg::sample_pair_t            pair,
   input  fir_pkg::tap_op_t                 op,
   output logic signed [fir_pkg::OUT_W-1:0] result,
   output logic                             result_stb
);
   import fir_pkg::*;

   logic signed [AD_W-1:0]   a, d;
   logic signed [COEF_W-1:0] b;
   logic signed [ACC_W-1:0]  p;
   logic [DSP_LAT-1:0]       last_pipe;  // bit DSP_LAT-1 high in the cycle p holds the sum

   // sign extend samples onto the 25 bit ports
   assign a = {{(AD_W - SAMPLE_W){pair.x_new[SAMPLE_W-1]}}, pair.x_new};
   assign d = {{(AD_W - SAMPLE_W){pair.x_old[SAMPLE_W-1]}}, pair.x_old};
   assign b = op.valid ? op.coef : '0;   // idle cycles add nothing

   dsp_slice u_dsp (
      .clock (clock),
      .a     (a),
      .d     (d),
      .b     (b),
      .c     (ROUND_C),
      .mode  (op.mode),
      .p     (p)
   );

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         last_pipe  <= '0;
         result_stb <= 1'b0;
      end else begin
         last_pipe  <= {last_pipe[DSP_LAT-2:0], op.last};
         result_stb <= last_pipe[DSP_LAT-1];
      end
   end

   // arithmetic shift down and truncate, held until the next pass
   always_ff @(posedge clock) begin
      if (last_pipe[DSP_LAT-1])
         result <= p[OUT_SHIFT +: OUT_W];
   end

endmodule

//--- fir_top.sv
// fir_top: 16 tap linear phase fir built from sequencer, delay line and mac stage
module fir_top (
   input  logic                                clock,
   input  logic                                arst_n,
   input  logic                                sample_stb,
   input  logic signed [fir_pkg::SAMPLE_W-1:0] sample,
   input  logic                                antisym,   // pre-subtract when set
   input  logic                                coef_we,
   input  logic [fir_pkg::PAIR_IDX_W-1:0]      coef_addr,
   input  logic signed [fir_pkg::COEF_W-1:0]   coef_data,
   output logic signed [fir_pkg::OUT_W-1:0]    result,
   output logic                                result_stb,
   output logic                                overrun
);
   import fir_pkg::*;

   logic                  sample_wr;
   logic                  tap_rd;
   logic [PAIR_IDX_W-1:0] pair_idx;
   tap_op_t               op;     // arrives with pair
   sample_pair_t          pair;

   tap_sequencer u_seq (
      .clock      (clock),
      .arst_n     (arst_n),
      .sample_stb (sample_stb),
      .antisym    (antisym),
      .coef_we    (coef_we),
      .coef_addr  (coef_addr),
      .coef_data  (coef_data),
      .sample_wr  (sample_wr),
      .tap_rd     (tap_rd),
      .pair_idx   (pair_idx),
      .op         (op),
      .overrun    (overrun)
   );

   sample_delay_line u_line (
      .clock     (clock),
      .sample_wr (sample_wr),
      .sample    (sample),
      .tap_rd    (tap_rd),
      .pair_idx  (pair_idx),
      .pair      (pair)
   );

   fir_mac u_mac (
      .clock      (clock),
      .arst_n     (arst_n),
      .pair       (pair),
      .op         (op),
      .result     (result),
      .result_stb (result_stb)
   );

endmodule

//--- fir_asserts.sv
// fir_asserts: bound checks on result strobe latency and overrun behavior, plus the bind
module fir_asserts (
   input logic clock,
   input logic arst_n,
   input logic sample_stb,
   input logic sample_wr,    // accepted strobe inside fir_top
   input logic overrun,
   input logic result_stb
);
   timeunit 1ns;
   timeprecision 1ps;
   import fir_pkg::*;

   // strobe seen at its accept edge, result_stb seen one edge after it rises at +14
   a_result_follows: assert property (@(posedge clock) disable iff (!arst_n)
      $past(sample_wr, NPAIRS + 7) |-> result_stb)
      else $error("result_stb missing after an accepted strobe");

   a_no_stray_result: assert property (@(posedge clock) disable iff (!arst_n)
      result_stb |-> $past(sample_wr, NPAIRS + 7))
      else $error("result_stb without an accepted strobe 14 cycles before");

   a_overrun_needs_stb: assert property (@(posedge clock) disable iff (!arst_n)
      overrun |-> sample_stb)
      else $error("overrun high without sample_stb");

endmodule

bind fir_top fir_asserts u_asserts (
   .clock      (clock),
   .arst_n     (arst_n),
   .sample_stb (sample_stb),
   .sample_wr  (sample_wr),
   .overrun    (overrun),
   .result_stb (result_stb)
);

//--- tb_fir.sv
// tb_fir: clock and reset, fir reference model, result monitor and directed tests
module tb_fir;
   timeunit 1ns;
   timeprecision 1ps;
   import fir_pkg::*;

   logic                       clock = 1'b0;
   logic                       arst_n;
   logic                       sample_stb;
   logic signed [SAMPLE_W-1:0] sample;
   logic                       antisym;
   logic                       coef_we;
   logic [PAIR_IDX_W-1:0]      coef_addr;
   logic signed [COEF_W-1:0]   coef_data;
   logic signed [OUT_W-1:0]    result;
   logic                       result_stb;
   logic                       overrun;

   longint coef_val [NPAIRS] = '{-104, 520, -1536, 4096, -9216, 20480, 57344, 98304};
   longint hist [NTAPS];                // model delay line, hist[0] newest
   logic signed [OUT_W-1:0] want_q [$]; // model results in order
   logic signed [OUT_W-1:0] got_q [$];  // dut results in order
   integer seed;
   int     errors = 0;
   int     timeouts = 0;
   int     overrun_cnt = 0;

   fir_top DUT (.*);

   always #10 clock = ~clock;  // 20 ns period

   // outputs are sampled mid cycle, away from the driving edge
   always @(negedge clock) begin
      if (result_stb)
         got_q.push_back(result);
      if (overrun)
         overrun_cnt++;
   end

   task automatic shift_history(input logic signed [SAMPLE_W-1:0] x);
      for (int i = NTAPS - 1; i > 0; i--)
         hist[i] = hist[i-1];
      hist[0] = x;
   endtask

   // sum over pairs of coef times the pre-add, round, shift down, truncate
   function automatic logic signed [OUT_W-1:0] model_out(input logic anti);
      longint acc;
      longint tap_sum;
      acc = longint'(ROUND_C);
      for (int k = 0; k < NPAIRS; k++) begin
         tap_sum = anti ? hist[k] - hist[NTAPS-1-k] : hist[k] + hist[NTAPS-1-k];
         acc += coef_val[k] * tap_sum;
      end
      return OUT_W'(acc >>> OUT_SHIFT);
   endfunction

   // one strobe, the next one may follow gap cycles later
   task automatic pulse_strobe(input logic signed [SAMPLE_W-1:0] x, input logic anti,
                               input int gap);
      @(posedge clock);
      sample_stb <= 1'b1;
      sample     <= x;
      antisym    <= anti;
      @(posedge clock);        // accepting edge
      sample_stb <= 1'b0;
      repeat (gap - 2) @(posedge clock);
   endtask

   task automatic send_sample(input logic signed [SAMPLE_W-1:0] x, input logic anti,
                              input int gap);
      shift_history(x);
      want_q.push_back(model_out(anti));
      pulse_strobe(x, anti, gap);
   endtask

   task automatic wait_results(input int n, input string tag);
      int waited;
      waited = 0;
      while (got_q.size() < n && waited < 40) begin
         @(negedge clock);
         waited++;
      end
      if (got_q.size() < n) begin
         timeouts++;
         $display("%s: timed out waiting for results, got %0d of %0d", tag, got_q.size(), n);
      end
      repeat (16) @(negedge clock);   // room for a stray strobe to show
   endtask

   task automatic check_results(input string tag);
      logic signed [OUT_W-1:0] got;
      logic signed [OUT_W-1:0] want;
      int idx;
      wait_results(want_q.size(), tag);
      assert (got_q.size() == want_q.size()) else begin
         errors++;
         $display("** Error at %0t: %s gave %0d results, expected %0d",
                  $time, tag, got_q.size(), want_q.size());
      end
      idx = 0;
      while (want_q.size() > 0 && got_q.size() > 0) begin
         want = want_q.pop_front();
         got  = got_q.pop_front();
         assert (got === want) else begin
            errors++;
            $display("** Error at %0t: %s result %0d is %0d, expected %0d",
                     $time, tag, idx, got, want);
         end
         idx++;
      end
      want_q.delete();
      got_q.delete();
   endtask

   task automatic load_coefs();
      for (int i = 0; i < NPAIRS; i++) begin
         @(posedge clock);
         coef_we   <= 1'b1;
         coef_addr <= PAIR_IDX_W'(i);
         coef_data <= COEF_W'(coef_val[i]);
      end
      @(posedge clock);
      coef_we <= 1'b0;
   endtask

   task automatic test_reset_idle();
      repeat (10) begin
         @(negedge clock);
         assert (result_stb == 1'b0 && overrun == 1'b0) else begin
            errors++;
            $display("** Error at %0t: strobe active after reset, result_stb %b overrun %b",
                     $time, result_stb, overrun);
         end
      end
   endtask

   task automatic prime_line();
      for (int i = 0; i < NTAPS; i++) begin
         hist[i] = 0;
         pulse_strobe('0, 1'b0, 9);
      end
      wait_results(NTAPS, "prime");
      got_q.delete();   // ring held unknowns until the last zero went in
   endtask

   task automatic test_impulse();
      logic signed [SAMPLE_W-1:0] x;
      for (int j = 0; j < NTAPS; j++) begin
         x = (j == 0) ? SAMPLE_W'(16384) : '0;
         shift_history(x);
         // 2^14 against a 17 bit shift reads each coef back divided by 8
         want_q.push_back(OUT_W'((j < NPAIRS ? coef_val[j] : coef_val[NTAPS-1-j]) / 8));
         pulse_strobe(x, 1'b0, 9);
      end
      check_results("impulse");
   endtask

   task automatic test_random(input logic anti, input string tag);
      logic signed [SAMPLE_W-1:0] x;
      seed = 16886;   // same stimulus for both modes
      for (int i = 0; i < 40; i++) begin
         x = SAMPLE_W'($random(seed));
         send_sample(x, anti, 9);
      end
      check_results(tag);
   endtask

   task automatic test_overrun();
      logic signed [SAMPLE_W-1:0] x;
      int ov_start;
      ov_start = overrun_cnt;
      send_sample(16'sd12000, 1'b0, 3);
      pulse_strobe(-16'sd7000, 1'b0, 9);   // lands while busy, model skips it
      for (int i = 0; i < 8; i++) begin
         x = SAMPLE_W'($random(seed));
         send_sample(x, 1'b0, 9);
      end
      check_results("overrun");
      assert (overrun_cnt - ov_start == 1) else begin
         errors++;
         $display("** Error at %0t: overrun pulsed %0d times, expected 1",
                  $time, overrun_cnt - ov_start);
      end
   endtask

   // minimum spacing with the mode flipping every pass and full scale samples
   task automatic test_back_to_back();
      logic signed [SAMPLE_W-1:0] x;
      for (int i = 0; i < 24; i++) begin
         x = (i % 6 == 0) ? -16'sd32768 : SAMPLE_W'($random(seed));
         send_sample(x, i[0], 9);
      end
      check_results("back to back");
   endtask

   initial begin
      arst_n     = 1'b0;
      sample_stb = 1'b0;
      sample     = '0;
      antisym    = 1'b0;
      coef_we    = 1'b0;
      coef_addr  = '0;
      coef_data  = '0;
      seed       = 16886;
      repeat (4) @(posedge clock);
      arst_n <= 1'b1;
      test_reset_idle();
      load_coefs();
      prime_line();
      test_impulse();
      test_random(1'b0, "symmetric");
      test_random(1'b1, "antisymmetric");
      test_overrun();
      test_back_to_back();
      $display("run complete, %0d errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

//--- filelist.f
fir_pkg.sv
dsp_slice.sv
sample_delay_line.sv
tap_sequencer.sv
fir_mac.sv
fir_top.sv
fir_asserts.sv
tb_fir.sv

//--- Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_fir -f filelist.f -o Vtb_fir

run: compile
	./obj_dir/Vtb_fir | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
